// File: common/id_pkg.sv
// RV32I base ISA only; no compressed, CSR, system or M-extension encodings exist here
package id_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and meaningful vector types
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN = 32;

  // Instruction, PC and operand words
  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      rf_addr_t;
  typedef logic [6:0]      opcode_t;

  // Register fields inside the instruction word
  localparam int REG_S1_MSB = 19;
  localparam int REG_S1_LSB = 15;
  localparam int REG_S2_MSB = 24;
  localparam int REG_S2_LSB = 20;
  localparam int REG_D_MSB  = 11;
  localparam int REG_D_LSB  = 7;

  // Base opcodes, bits 6..0
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;

  // Hardened control flow, every jump or branch issues two operations
  localparam int JMP_BCH_OPS    = 2;
  localparam int MULTI_OP_CNT_W = 1;
  typedef logic [MULTI_OP_CNT_W-1:0] op_cnt_t;

  // Link increment, no compressed instructions
  localparam int PC_INCR = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR,  ALU_AND, ALU_EQ,  ALU_NE,  ALU_LT,   ALU_GE,  ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO, OP_A_NONE} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM, OP_B_NONE} op_b_sel_e;
  typedef enum logic [1:0] {OP_C_REG, OP_C_BCH, OP_C_NONE} op_c_sel_e;
  typedef enum logic [1:0] {IMMB_I, IMMB_S, IMMB_U, IMMB_PCINCR} imm_b_sel_e;
  typedef enum logic [1:0] {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB} fw_sel_e;

  // Matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {LSU_BYTE, LSU_HALF, LSU_WORD} lsu_size_e;

  ////////////////////////////////////////////////////////////////////////////
  // Stage structs
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    word_t instr;
    word_t pc;
  } if_id_t;

  typedef struct packed {
    fw_sel_e op_a_fw_sel;
    fw_sel_e op_b_fw_sel;
  } byp_sel_t;

  typedef struct packed {
    logic       alu_en;
    logic       alu_bch;
    logic       alu_jmp;
    logic       alu_jmpr;
    alu_op_e    alu_op;
    logic       lsu_en;
    logic       lsu_we;
    lsu_size_e  lsu_size;
    logic       lsu_sext;
    logic       rf_we;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    op_c_sel_e  op_c_sel;
    imm_b_sel_e imm_b_sel;
    logic       illegal;
  } dec_ctrl_t;

  typedef struct packed {
    logic      instr_valid;
    word_t     pc;
    word_t     instr;
    logic      alu_en;
    logic      alu_bch;
    logic      alu_jmp;
    alu_op_e   alu_op;
    word_t     alu_operand_a;
    word_t     alu_operand_b;
    word_t     operand_c;
    logic      lsu_en;
    logic      lsu_we;
    lsu_size_e lsu_size;
    logic      lsu_sext;
    logic      rf_we;
    rf_addr_t  rf_waddr;
    logic      illegal_insn;
    logic      first_op;
    logic      last_op;
  } id_ex_t;

endpackage

// File: decoder/id_decoder.sv
// Pure combinational RV32I decode; FENCE, SYSTEM and any other opcode are flagged illegal
module id_decoder (
  input  id_pkg::word_t     instr_i,
  output id_pkg::dec_ctrl_t ctrl_o,
  output logic [1:0]        rf_re_o
);

  id_pkg::opcode_t opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [1:0]      rf_re;
  logic            illegal;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Shared by OP and OP-IMM, alt picks SUB or SRA
  function automatic id_pkg::alu_op_e alu_op_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_op_of = alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  alu_op_of = id_pkg::ALU_SLL;
      3'b010:  alu_op_of = id_pkg::ALU_SLT;
      3'b011:  alu_op_of = id_pkg::ALU_SLTU;
      3'b100:  alu_op_of = id_pkg::ALU_XOR;
      3'b101:  alu_op_of = alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  alu_op_of = id_pkg::ALU_OR;
      default: alu_op_of = id_pkg::ALU_AND;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Nothing enabled, no operand captured
    ctrl_o           = '0;
    ctrl_o.op_a_sel  = id_pkg::OP_A_NONE;
    ctrl_o.op_b_sel  = id_pkg::OP_B_NONE;
    ctrl_o.op_c_sel  = id_pkg::OP_C_NONE;
    ctrl_o.imm_b_sel = id_pkg::IMMB_I;
    ctrl_o.lsu_size  = id_pkg::LSU_WORD;
    rf_re            = 2'b00;
    illegal          = 1'b0;

    case (opcode)
      id_pkg::OPC_OP: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.alu_op   = alu_op_of(funct3, funct7[5]);
        ctrl_o.op_a_sel = id_pkg::OP_A_REG;
        ctrl_o.op_b_sel = id_pkg::OP_B_REG;
        rf_re           = 2'b11;
        // Only SUB and SRA carry funct7 0100000
        illegal = !((funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      id_pkg::OPC_OP_IMM: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.alu_op   = alu_op_of(funct3, (funct3 == 3'b101) && funct7[5]);
        ctrl_o.op_a_sel = id_pkg::OP_A_REG;
        ctrl_o.op_b_sel = id_pkg::OP_B_IMM;
        rf_re           = 2'b01;
        // Shift amounts leave funct7 for the shift kind
        if (funct3 == 3'b001) begin
          illegal = (funct7 != 7'b0000000);
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end
      end
      id_pkg::OPC_LUI, id_pkg::OPC_AUIPC: begin
        ctrl_o.alu_en    = 1'b1;
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.op_a_sel  = (opcode == id_pkg::OPC_LUI) ? id_pkg::OP_A_ZERO : id_pkg::OP_A_PC;
        ctrl_o.op_b_sel  = id_pkg::OP_B_IMM;
        ctrl_o.imm_b_sel = id_pkg::IMMB_U;
      end
      id_pkg::OPC_JAL, id_pkg::OPC_JALR: begin
        // Link value PC + 4 is formed by the ALU add
        ctrl_o.alu_en    = 1'b1;
        ctrl_o.alu_jmp   = 1'b1;
        ctrl_o.alu_jmpr  = (opcode == id_pkg::OPC_JALR);
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.op_a_sel  = id_pkg::OP_A_PC;
        ctrl_o.op_b_sel  = id_pkg::OP_B_IMM;
        ctrl_o.imm_b_sel = id_pkg::IMMB_PCINCR;
        rf_re            = {1'b0, opcode == id_pkg::OPC_JALR};
        illegal          = (opcode == id_pkg::OPC_JALR) && (funct3 != 3'b000);
      end
      id_pkg::OPC_BRANCH: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.alu_bch  = 1'b1;
        ctrl_o.op_a_sel = id_pkg::OP_A_REG;
        ctrl_o.op_b_sel = id_pkg::OP_B_REG;
        ctrl_o.op_c_sel = id_pkg::OP_C_BCH;
        rf_re           = 2'b11;
        case (funct3)
          3'b000:  ctrl_o.alu_op = id_pkg::ALU_EQ;
          3'b001:  ctrl_o.alu_op = id_pkg::ALU_NE;
          3'b100:  ctrl_o.alu_op = id_pkg::ALU_LT;
          3'b101:  ctrl_o.alu_op = id_pkg::ALU_GE;
          3'b110:  ctrl_o.alu_op = id_pkg::ALU_LTU;
          3'b111:  ctrl_o.alu_op = id_pkg::ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      id_pkg::OPC_LOAD: begin
        // Address add happens in the LSU
        ctrl_o.lsu_en   = 1'b1;
        ctrl_o.lsu_size = id_pkg::lsu_size_e'(funct3[1:0]);
        ctrl_o.lsu_sext = !funct3[2];
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = id_pkg::OP_A_REG;
        ctrl_o.op_b_sel = id_pkg::OP_B_IMM;
        rf_re           = 2'b01;
        illegal         = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      id_pkg::OPC_STORE: begin
        ctrl_o.lsu_en    = 1'b1;
        ctrl_o.lsu_we    = 1'b1;
        ctrl_o.lsu_size  = id_pkg::lsu_size_e'(funct3[1:0]);
        ctrl_o.op_a_sel  = id_pkg::OP_A_REG;
        ctrl_o.op_b_sel  = id_pkg::OP_B_IMM;
        ctrl_o.imm_b_sel = id_pkg::IMMB_S;
        // Store data rides in operand C
        ctrl_o.op_c_sel  = id_pkg::OP_C_REG;
        rf_re            = 2'b11;
        illegal          = funct3[2] || (funct3[1:0] == 2'b11);
      end
      default: illegal = 1'b1;
    endcase

    // Illegal encodings must not touch any unit or the register file
    if (illegal) begin
      ctrl_o.alu_en   = 1'b0;
      ctrl_o.alu_bch  = 1'b0;
      ctrl_o.alu_jmp  = 1'b0;
      ctrl_o.alu_jmpr = 1'b0;
      ctrl_o.lsu_en   = 1'b0;
      ctrl_o.lsu_we   = 1'b0;
      ctrl_o.rf_we    = 1'b0;
    end
    ctrl_o.illegal = illegal;
  end

  // Read both sources when the encoding is unknown
  assign rf_re_o = illegal ? 2'b11 : rf_re;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing -f sim.f --top-module tb_id_stage -o tb_id_stage 2>&1 \
  && ./obj_dir/tb_id_stage 2>&1) || { echo "$out"; echo "build or simulation failed"; exit 1; }
echo "$out"
echo "$out" | grep -qx "ALL TESTS PASSED" && exit 0 || exit 1

// File: sim.f
+incdir+test
common/id_pkg.sv
decoder/id_decoder.sv
source/id_operand_path.sv
source/id_stage_ctrl.sv
source/id_ex_pipe_reg.sv
source/id_stage.sv
test/tb_id_stage.sv

// File: source/id_ex_pipe_reg.sv
// ID/EX register; gated fields keep stale values that EX must ignore when the unit is off
module id_ex_pipe_reg (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              id_valid_i,
  input  logic              ex_ready_i,
  input  id_pkg::if_id_t    if_id_i,
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  id_pkg::word_t     operand_a_i,
  input  id_pkg::word_t     operand_b_i,
  input  id_pkg::word_t     operand_c_i,
  input  id_pkg::rf_addr_t  rf_waddr_i,
  input  logic              first_op_i,
  input  logic              last_op_i,
  output id_pkg::id_ex_t    id_ex_o
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_o <= '0;
    end else if (id_valid_i && ex_ready_i) begin
      id_ex_o.instr_valid  <= 1'b1;
      id_ex_o.pc           <= if_id_i.pc;
      id_ex_o.instr        <= if_id_i.instr;
      id_ex_o.illegal_insn <= ctrl_i.illegal;
      id_ex_o.first_op     <= first_op_i;
      id_ex_o.last_op      <= last_op_i;

      // Enables are always taken
      id_ex_o.alu_en <= ctrl_i.alu_en;
      id_ex_o.lsu_en <= ctrl_i.lsu_en;
      id_ex_o.rf_we  <= ctrl_i.rf_we;

      // Unit fields only toggle when the unit is used
      if (ctrl_i.alu_en) begin
        id_ex_o.alu_bch <= ctrl_i.alu_bch;
        id_ex_o.alu_jmp <= ctrl_i.alu_jmp;
        id_ex_o.alu_op  <= ctrl_i.alu_op;
      end
      if (ctrl_i.lsu_en) begin
        id_ex_o.lsu_we   <= ctrl_i.lsu_we;
        id_ex_o.lsu_size <= ctrl_i.lsu_size;
        id_ex_o.lsu_sext <= ctrl_i.lsu_sext;
      end

      // Operands
      if (ctrl_i.op_a_sel != id_pkg::OP_A_NONE) begin
        id_ex_o.alu_operand_a <= operand_a_i;
      end
      if (ctrl_i.op_b_sel != id_pkg::OP_B_NONE) begin
        id_ex_o.alu_operand_b <= operand_b_i;
      end
      if (ctrl_i.op_c_sel != id_pkg::OP_C_NONE) begin
        id_ex_o.operand_c <= operand_c_i;
      end
      if (ctrl_i.rf_we) begin
        id_ex_o.rf_waddr <= rf_waddr_i;
      end
    end else if (ex_ready_i) begin
      // EX took the old entry and nothing new came
      id_ex_o.instr_valid <= 1'b0;
    end
  end

endmodule

// File: source/id_operand_path.sv
// Combinational operand path; JALR target uses the forwarded rs1 value, same as operand A
module id_operand_path (
  input  id_pkg::word_t     instr_i,
  input  id_pkg::word_t     pc_i,
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  id_pkg::byp_sel_t  byp_sel_i,
  input  id_pkg::word_t     rf_rdata_a_i,
  input  id_pkg::word_t     rf_rdata_b_i,
  input  id_pkg::word_t     rf_wdata_ex_i,
  input  id_pkg::word_t     rf_wdata_wb_i,
  output id_pkg::word_t     operand_a_o,
  output id_pkg::word_t     operand_b_o,
  output id_pkg::word_t     operand_c_o,
  output id_pkg::word_t     jmp_target_o
);

  id_pkg::word_t imm_i;
  id_pkg::word_t imm_s;
  id_pkg::word_t imm_b;
  id_pkg::word_t imm_u;
  id_pkg::word_t imm_j;
  id_pkg::word_t imm_op_b;
  id_pkg::word_t operand_a_fw;
  id_pkg::word_t operand_b_fw;
  id_pkg::word_t bch_target;
  id_pkg::word_t jalr_target;

  // Same three-way pick for both read ports
  function automatic id_pkg::word_t fw_mux(input id_pkg::fw_sel_e sel, input id_pkg::word_t rf,
                                           input id_pkg::word_t ex, input id_pkg::word_t wb);
    case (sel)
      id_pkg::SEL_FW_EX: fw_mux = ex;
      id_pkg::SEL_FW_WB: fw_mux = wb;
      default:           fw_mux = rf;
    endcase
  endfunction

  // Sign-extended immediates, bit 31 is always the sign
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  assign operand_a_fw = fw_mux(byp_sel_i.op_a_fw_sel, rf_rdata_a_i, rf_wdata_ex_i, rf_wdata_wb_i);
  assign operand_b_fw = fw_mux(byp_sel_i.op_b_fw_sel, rf_rdata_b_i, rf_wdata_ex_i, rf_wdata_wb_i);

  always_comb begin
    case (ctrl_i.imm_b_sel)
      id_pkg::IMMB_S:      imm_op_b = imm_s;
      id_pkg::IMMB_U:      imm_op_b = imm_u;
      id_pkg::IMMB_PCINCR: imm_op_b = id_pkg::word_t'(id_pkg::PC_INCR);
      default:             imm_op_b = imm_i;
    endcase
  end

  // Operand A, NONE still shows rs1 since the pipe register skips it
  always_comb begin
    case (ctrl_i.op_a_sel)
      id_pkg::OP_A_PC:   operand_a_o = pc_i;
      id_pkg::OP_A_ZERO: operand_a_o = '0;
      default:           operand_a_o = operand_a_fw;
    endcase
  end

  assign operand_b_o = (ctrl_i.op_b_sel == id_pkg::OP_B_IMM) ? imm_op_b : operand_b_fw;

  // Operand C carries store data or the branch target
  assign operand_c_o = (ctrl_i.op_c_sel == id_pkg::OP_C_BCH) ? bch_target : operand_b_fw;

  ////////////////////////////////////////////////////////////////////////////
  // Target adders
  ////////////////////////////////////////////////////////////////////////////

  assign bch_target  = pc_i + imm_b;
  assign jalr_target = operand_a_fw + imm_i;

  // JALR clears bit 0 of the sum
  assign jmp_target_o = ctrl_i.alu_jmpr ? {jalr_target[id_pkg::XLEN-1:1], 1'b0}
                                        : pc_i + imm_j;

endmodule

// File: source/id_stage.sv
// Decode stage top; register file read data must arrive combinationally in the same cycle
module id_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  id_pkg::if_id_t   if_id_i,
  input  logic             if_valid_i,
  input  logic             ex_ready_i,
  input  id_pkg::byp_sel_t byp_sel_i,
  input  id_pkg::word_t    rf_rdata_a_i,
  input  id_pkg::word_t    rf_rdata_b_i,
  input  id_pkg::word_t    rf_wdata_ex_i,
  input  id_pkg::word_t    rf_wdata_wb_i,
  output logic             id_ready_o,
  output id_pkg::id_ex_t   id_ex_o,
  output id_pkg::rf_addr_t rf_raddr_a_o,
  output id_pkg::rf_addr_t rf_raddr_b_o,
  output logic [1:0]       rf_re_o,
  output id_pkg::word_t    jmp_target_o
);

  id_pkg::dec_ctrl_t ctrl;
  id_pkg::word_t     operand_a;
  id_pkg::word_t     operand_b;
  id_pkg::word_t     operand_c;
  id_pkg::rf_addr_t  rf_waddr;
  logic              id_valid;
  logic              first_op;
  logic              last_op;

  // Register fields straight from the instruction word
  assign rf_raddr_a_o = if_id_i.instr[id_pkg::REG_S1_MSB:id_pkg::REG_S1_LSB];
  assign rf_raddr_b_o = if_id_i.instr[id_pkg::REG_S2_MSB:id_pkg::REG_S2_LSB];
  assign rf_waddr     = if_id_i.instr[id_pkg::REG_D_MSB:id_pkg::REG_D_LSB];

  ////////////////////////////////////////////////////////////////////////////
  // Decode, operands, control and the ID/EX register
  ////////////////////////////////////////////////////////////////////////////

  id_decoder u_decoder (
    .instr_i (if_id_i.instr),
    .ctrl_o  (ctrl),
    .rf_re_o (rf_re_o)
  );

  id_operand_path u_operand_path (
    .instr_i       (if_id_i.instr),
    .pc_i          (if_id_i.pc),
    .ctrl_i        (ctrl),
    .byp_sel_i     (byp_sel_i),
    .rf_rdata_a_i  (rf_rdata_a_i),
    .rf_rdata_b_i  (rf_rdata_b_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .operand_c_o   (operand_c),
    .jmp_target_o  (jmp_target_o)
  );

  id_stage_ctrl u_stage_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .if_valid_i (if_valid_i),
    .ex_ready_i (ex_ready_i),
    .ctrl_i     (ctrl),
    .id_valid_o (id_valid),
    .id_ready_o (id_ready_o),
    .first_op_o (first_op),
    .last_op_o  (last_op)
  );

  id_ex_pipe_reg u_pipe_reg (
    .clk         (clk),
    .rst_n       (rst_n),
    .id_valid_i  (id_valid),
    .ex_ready_i  (ex_ready_i),
    .if_id_i     (if_id_i),
    .ctrl_i      (ctrl),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .operand_c_i (operand_c),
    .rf_waddr_i  (rf_waddr),
    .first_op_i  (first_op),
    .last_op_i   (last_op),
    .id_ex_o     (id_ex_o)
  );

endmodule

// File: source/id_stage_ctrl.sv
// Stage handshake; jumps and branches hold fetch off until their second operation leaves
module id_stage_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              if_valid_i,
  input  logic              ex_ready_i,
  input  id_pkg::dec_ctrl_t ctrl_i,
  output logic              id_valid_o,
  output logic              id_ready_o,
  output logic              first_op_o,
  output logic              last_op_o
);

  id_pkg::op_cnt_t op_cnt;
  logic            jmp_bch;
  logic            xfer;

  // Jumps and branches are the only multi-operation instructions
  assign jmp_bch = ctrl_i.alu_en && (ctrl_i.alu_bch || ctrl_i.alu_jmp);

  assign first_op_o = jmp_bch ? (op_cnt == '0) : 1'b1;
  assign last_op_o  = jmp_bch ? (op_cnt == id_pkg::op_cnt_t'(id_pkg::JMP_BCH_OPS - 1)) : 1'b1;

  // Valid follows fetch, the operation count only gates ready
  assign id_valid_o = if_valid_i;
  assign xfer       = id_valid_o && ex_ready_i;

  // Fetch is released together with the last operation only
  assign id_ready_o = ex_ready_i && last_op_o;

  ////////////////////////////////////////////////////////////////////////////
  // Operation counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_cnt <= '0;
    end else if (xfer) begin
      if (last_op_o) begin
        // Instruction done, next one starts at zero
        op_cnt <= '0;
      end else begin
        op_cnt <= op_cnt + id_pkg::op_cnt_t'(1);
      end
    end
  end

endmodule

// File: test/tb_id_vectors.svh
// Directed rows for the decode stage; all expected values are hand-encoded RV32I results
`ifndef TB_ID_VECTORS_SVH
`define TB_ID_VECTORS_SVH

// One row per instruction with its register file model values
typedef struct packed {
  id_pkg::word_t      instr;
  id_pkg::word_t      pc;
  id_pkg::word_t      rd_a;
  id_pkg::word_t      rd_b;
  id_pkg::fw_sel_e    sel_a;
  id_pkg::fw_sel_e    sel_b;
  id_pkg::word_t      wd_ex;
  id_pkg::word_t      wd_wb;
  logic [3:0]         stall;
  logic               alu_en;
  logic               lsu_en;
  logic               rf_we;
  logic               illegal;
  logic               bch;
  logic               jmp;
  id_pkg::alu_op_e    alu_op;
  logic               lsu_we;
  id_pkg::lsu_size_e  size;
  logic               sext;
  logic [1:0]         rf_re;
  logic               chk_ab;
  id_pkg::word_t      exp_a;
  id_pkg::word_t      exp_b;
  logic               chk_c;
  id_pkg::word_t      exp_c;
  logic               chk_jt;
  id_pkg::word_t      exp_jt;
} vec_t;

vec_t vec_q[$];

////////////////////////////////////////////////////////////////////////////
// Directed table
////////////////////////////////////////////////////////////////////////////

task automatic load_fixed_vectors();
  // ADD x3, x1, x2
  vec_q.push_back('{32'h002081B3, 32'h00000100, 32'h11111111, 32'h22222222,
    id_pkg::SEL_REGFILE, id_pkg::SEL_REGFILE, 32'hE0E0E0E0, 32'h0B0B0B0B, 4'd0,
    1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, id_pkg::ALU_ADD, 1'b0, id_pkg::LSU_WORD, 1'b0, 2'b11,
    1'b1, 32'h11111111, 32'h22222222, 1'b0, 32'h0, 1'b0, 32'h0});
  // SUB x5, x6, x7 with both operands forwarded and EX stalled
  vec_q.push_back('{32'h407302B3, 32'h00000104, 32'h12340000, 32'h00005678,
    id_pkg::SEL_FW_EX, id_pkg::SEL_FW_WB, 32'hAAAA0000, 32'h0000BBBB, 4'd3,
    1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, id_pkg::ALU_SUB, 1'b0, id_pkg::LSU_WORD, 1'b0, 2'b11,
    1'b1, 32'hAAAA0000, 32'h0000BBBB, 1'b0, 32'h0, 1'b0, 32'h0});
  // ADDI x4, x1, -5
  vec_q.push_back('{32'hFFB08213, 32'h00000108, 32'h00000010, 32'h00000099,
    id_pkg::SEL_REGFILE, id_pkg::SEL_REGFILE, 32'h0, 32'h0, 4'd0,
    1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, id_pkg::ALU_ADD, 1'b0, id_pkg::LSU_WORD, 1'b0, 2'b01,
    1'b1, 32'h00000010, 32'hFFFFFFFB, 1'b0, 32'h0, 1'b0, 32'h0});
  // SRAI x8, x9, 3 with rs1 from WB
  vec_q.push_back('{32'h4034D413, 32'h0000010C, 32'h80000000, 32'h0,
    id_pkg::SEL_FW_WB, id_pkg::SEL_REGFILE, 32'h0, 32'hF0000000, 4'd0,
    1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, id_pkg::ALU_SRA, 1'b0, id_pkg::LSU_WORD, 1'b0, 2'b01,
    1'b1, 32'hF0000000, 32'h00000403, 1'b0, 32'h0, 1'b0, 32'h0});
  // LUI x10, 0x12345
  vec_q.push_back('{32'h12345537, 32'h00000110, 32'h0, 32'h0,
    id_pkg::SEL_REGFILE, id_pkg::SEL_REGFILE, 32'h0, 32'h0, 4'd0,
    1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, id_pkg::ALU_ADD, 1'b0, id_pkg::LSU_WORD, 1'b0, 2'b00,
    1'b1, 32'h0, 32'h12345000, 1'b0, 32'h0, 1'b0, 32'h0});
  // AUIPC x11, 0xFFFFF
  vec_q.push_back('{32'hFFFFF597, 32'h00001000, 32'h0, 32'h0,
    id_pkg::SEL_REGFILE, id_pkg::SEL_REGFILE, 32'h0, 32'h0, 4'd0,
    1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, id_pkg::ALU_ADD, 1'b0, id_pkg::LSU_WORD, 1'b0, 2'b00,
    1'b1, 32'h00001000, 32'hFFFFF000, 1'b0, 32'h0, 1'b0, 32'h0});
  // LW x12, -4(x2)
  vec_q.push_back('{32'hFFC12603, 32'h00001004, 32'h00002000, 32'h0,
    id_pkg::SEL_REGFILE, id_pkg::SEL_REGFILE, 32'h0, 32'h0, 4'd0,
    1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, id_pkg::ALU_ADD, 1'b0, id_pkg::LSU_WORD, 1'b1, 2'b01,
    1'b1, 32'h00002000, 32'hFFFFFFFC, 1'b0, 32'h0, 1'b0, 32'h0});
  // LBU x13, 7(x1) with rs1 from EX
  vec_q.push_back('{32'h0070C683, 32'h00001008, 32'h00003000, 32'h0,
    id_pkg::SEL_FW_EX, id_pkg::SEL_REGFILE, 32'h00004000, 32'h0, 4'd0,
    1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, id_pkg::ALU_ADD, 1'b0, id_pkg::LSU_BYTE, 1'b0, 2'b01,
    1'b1, 32'h00004000, 32'h00000007, 1'b0, 32'h0, 1'b0, 32'h0});
  // SH x5, -8(x3) with store data forwarded from EX and EX stalled
  vec_q.push_back('{32'hFE519C23, 32'h0000100C, 32'h00000500, 32'h00001234,
    id_pkg::SEL_REGFILE, id_pkg::SEL_FW_EX, 32'h0000CAFE, 32'h0, 4'd2,
    1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, id_pkg::ALU_ADD, 1'b1, id_pkg::LSU_HALF, 1'b0, 2'b11,
    1'b1, 32'h00000500, 32'hFFFFFFF8, 1'b1, 32'h0000CAFE, 1'b0, 32'h0});
  // JAL x1, +0x800
  vec_q.push_back('{32'h001000EF, 32'h00002000, 32'h0, 32'h0,
    id_pkg::SEL_REGFILE, id_pkg::SEL_REGFILE, 32'h0, 32'h0, 4'd0,
    1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, id_pkg::ALU_ADD, 1'b0, id_pkg::LSU_WORD, 1'b0, 2'b00,
    1'b1, 32'h00002000, 32'h00000004, 1'b0, 32'h0, 1'b1, 32'h00002800});
  // JALR x0, 12(x6) whose odd sum loses bit 0 and whose first operation stalls
  vec_q.push_back('{32'h00C30067, 32'h00002800, 32'h00003001, 32'h0,
    id_pkg::SEL_REGFILE, id_pkg::SEL_REGFILE, 32'h0, 32'h0, 4'd1,
    1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, id_pkg::ALU_ADD, 1'b0, id_pkg::LSU_WORD, 1'b0, 2'b01,
    1'b1, 32'h00002800, 32'h00000004, 1'b0, 32'h0, 1'b1, 32'h0000300C});
  // BNE x1, x2, -16 with rs2 from WB
  vec_q.push_back('{32'hFE2098E3, 32'h00003000, 32'h00000005, 32'h00000006,
    id_pkg::SEL_REGFILE, id_pkg::SEL_FW_WB, 32'h0, 32'h00000077, 4'd0,
    1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, id_pkg::ALU_NE, 1'b0, id_pkg::LSU_WORD, 1'b0, 2'b11,
    1'b1, 32'h00000005, 32'h00000077, 1'b1, 32'h00002FF0, 1'b0, 32'h0});
  // Unknown opcode 1111111
  vec_q.push_back('{32'h0000007F, 32'h00003004, 32'h0, 32'h0,
    id_pkg::SEL_REGFILE, id_pkg::SEL_REGFILE, 32'h0, 32'h0, 4'd0,
    1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, id_pkg::ALU_ADD, 1'b0, id_pkg::LSU_WORD, 1'b0, 2'b11,
    1'b0, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0});
endtask

`endif

// File: test/tb_id_stage.sv
// Drives the decode stage from a row table; each row is released before the next one starts
module tb_id_stage;

  logic               clk;
  logic               rst_n;
  id_pkg::if_id_t     if_id;
  logic               if_valid;
  logic               ex_ready;
  id_pkg::byp_sel_t   byp_sel;
  id_pkg::word_t      rf_rdata_a;
  id_pkg::word_t      rf_rdata_b;
  id_pkg::word_t      rf_wdata_ex;
  id_pkg::word_t      rf_wdata_wb;
  logic               id_ready;
  id_pkg::id_ex_t     id_ex;
  id_pkg::rf_addr_t   rf_raddr_a;
  id_pkg::rf_addr_t   rf_raddr_b;
  logic [1:0]         rf_re;
  id_pkg::word_t      jmp_target;

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          limit = 100000;
  logic [15:0] lfsr_state = 16'd39597;

  `include "tb_id_vectors.svh"

  id_stage dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_id_i       (if_id),
    .if_valid_i    (if_valid),
    .ex_ready_i    (ex_ready),
    .byp_sel_i     (byp_sel),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .rf_wdata_ex_i (rf_wdata_ex),
    .rf_wdata_wb_i (rf_wdata_wb),
    .id_ready_o    (id_ready),
    .id_ex_o       (id_ex),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .rf_re_o       (rf_re),
    .jmp_target_o  (jmp_target)
  );

  always #2 clk = ~clk;

  // Run limit grows with the table length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic compare_values(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at time %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] result;
    logic        lsb;
    result = '0;
    for (int i = 0; i < n; i++) begin
      lsb        = lfsr_state[0];
      lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lsb ? 16'hB400 : 16'h0000);
      result     = {result[30:0], lsb};
    end
    return result;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Random ADDI rows, expected values from the I immediate and forward selects
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_random_rows(input int n);
    vec_t        v;
    logic [31:0] imm;
    logic [31:0] rs1;
    logic [31:0] rd;
    logic [31:0] sel;
    logic [31:0] stall;
    for (int i = 0; i < n; i++) begin
      v       = '0;
      imm     = take_bits(12);
      rs1     = take_bits(5);
      rd      = take_bits(5);
      v.instr = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], id_pkg::OPC_OP_IMM};
      v.pc    = 32'h00004000 + 32'(4 * i);
      v.rd_a  = take_bits(32);
      v.rd_b  = take_bits(32);
      v.wd_ex = take_bits(32);
      v.wd_wb = take_bits(32);
      sel     = take_bits(2);
      stall   = take_bits(2);
      v.stall = {2'b00, stall[1:0]};
      v.sel_b = id_pkg::SEL_REGFILE;
      case (sel[1:0])
        2'd1: begin
          v.sel_a = id_pkg::SEL_FW_EX;
          v.exp_a = v.wd_ex;
        end
        2'd2: begin
          v.sel_a = id_pkg::SEL_FW_WB;
          v.exp_a = v.wd_wb;
        end
        default: begin
          v.sel_a = id_pkg::SEL_REGFILE;
          v.exp_a = v.rd_a;
        end
      endcase
      v.exp_b  = {{20{imm[11]}}, imm[11:0]};
      v.alu_en = 1'b1;
      v.rf_we  = 1'b1;
      v.alu_op = id_pkg::ALU_ADD;
      v.size   = id_pkg::LSU_WORD;
      v.rf_re  = 2'b01;
      v.chk_ab = 1'b1;
      vec_q.push_back(v);
    end
  endtask

  task automatic check_output(input vec_t v, input logic first, input logic last);
    compare_values("instr_valid", 32'(id_ex.instr_valid), 32'd1);
    compare_values("pc", id_ex.pc, v.pc);
    compare_values("instr", id_ex.instr, v.instr);
    compare_values("illegal_insn", 32'(id_ex.illegal_insn), 32'(v.illegal));
    compare_values("alu_en", 32'(id_ex.alu_en), 32'(v.alu_en));
    compare_values("lsu_en", 32'(id_ex.lsu_en), 32'(v.lsu_en));
    compare_values("rf_we", 32'(id_ex.rf_we), 32'(v.rf_we));
    compare_values("first_op", 32'(id_ex.first_op), 32'(first));
    compare_values("last_op", 32'(id_ex.last_op), 32'(last));
    if (v.alu_en) begin
      compare_values("alu_op", 32'(id_ex.alu_op), 32'(v.alu_op));
      compare_values("alu_bch", 32'(id_ex.alu_bch), 32'(v.bch));
      compare_values("alu_jmp", 32'(id_ex.alu_jmp), 32'(v.jmp));
    end
    if (v.lsu_en) begin
      compare_values("lsu_we", 32'(id_ex.lsu_we), 32'(v.lsu_we));
      compare_values("lsu_size", 32'(id_ex.lsu_size), 32'(v.size));
      compare_values("lsu_sext", 32'(id_ex.lsu_sext), 32'(v.sext));
    end
    if (v.chk_ab) begin
      compare_values("operand_a", id_ex.alu_operand_a, v.exp_a);
      compare_values("operand_b", id_ex.alu_operand_b, v.exp_b);
    end
    if (v.chk_c) begin
      compare_values("operand_c", id_ex.operand_c, v.exp_c);
    end
    // Destination is bits 11..7
    if (v.rf_we) begin
      compare_values("rf_waddr", 32'(id_ex.rf_waddr), 32'(v.instr[11:7]));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One row: stall, then transfers until fetch is released
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_row(input vec_t v);
    id_pkg::id_ex_t snap;
    int             ops;
    int             nops;
    logic           released;
    logic           jb;
    jb          = v.bch | v.jmp;
    nops        = jb ? 2 : 1;
    if_id.instr = v.instr;
    if_id.pc    = v.pc;
    if_valid    = 1'b1;
    byp_sel     = '{op_a_fw_sel: v.sel_a, op_b_fw_sel: v.sel_b};
    rf_rdata_a  = v.rd_a;
    rf_rdata_b  = v.rd_b;
    rf_wdata_ex = v.wd_ex;
    rf_wdata_wb = v.wd_wb;
    ex_ready    = (v.stall == 4'd0);
    snap        = id_ex;
    #1;
    compare_values("rf_raddr_a", 32'(rf_raddr_a), 32'(v.instr[19:15]));
    compare_values("rf_raddr_b", 32'(rf_raddr_b), 32'(v.instr[24:20]));
    compare_values("rf_re", 32'(rf_re), 32'(v.rf_re));
    if (v.chk_jt) begin
      compare_values("jmp_target", jmp_target, v.exp_jt);
    end
    // EX held off, register frozen and fetch not released
    for (int s = 0; s < int'(v.stall); s++) begin
      compare_values("id_ready stalled", 32'(id_ready), 32'd0);
      @(posedge clk);
      #1;
      compare_values("id_ex held", 32'(id_ex == snap), 32'd1);
      if (s == int'(v.stall) - 1) begin
        ex_ready = 1'b1;
      end
      #1;
    end
    ops      = 0;
    released = 1'b0;
    while (!released) begin
      compare_values("id_ready", 32'(id_ready), 32'(!jb || ops == nops - 1));
      released = id_ready;
      @(posedge clk);
      #1;
      check_output(v, ops == 0, !jb || ops == nops - 1);
      ops++;
      if (!released) begin
        #1;
      end
    end
    compare_values("operation count", 32'(ops), 32'(nops));
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    if_id       = '0;
    if_valid    = 1'b0;
    ex_ready    = 1'b0;
    byp_sel     = '0;
    rf_rdata_a  = '0;
    rf_rdata_b  = '0;
    rf_wdata_ex = '0;
    rf_wdata_wb = '0;
    load_fixed_vectors();
    add_random_rows(6);
    limit = vec_q.size() * 8 + 50;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    compare_values("reset state", 32'({id_ex.instr_valid, id_ex.rf_we, id_ex.alu_en,
                                       id_ex.lsu_en, id_ex.first_op, id_ex.last_op}), 32'd0);
    foreach (vec_q[i]) begin
      run_row(vec_q[i]);
    end
    // EX ready with nothing new clears the valid
    if_valid = 1'b0;
    ex_ready = 1'b1;
    @(posedge clk);
    #1;
    compare_values("instr_valid idle", 32'(id_ex.instr_valid), 32'd0);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
